/* sim.f */
verilog/mprj_ctrl_pkg.sv
verilog/mprj_ctrl_regs.sv
verilog/serial_cfg_loader.sv
verilog/pad_cfg_chain.sv
verilog/mprj_ctrl_top.sv
testbench/mprj_ctrl_asserts.sv
testbench/tb_mprj_ctrl.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mprj_ctrl -f sim.f -Mdir obj_dir -o tb_mprj_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mprj_ctrl +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
    exit 1
fi
exit 0

/* testbench/tb_mprj_ctrl.sv */
// Testbench for the user-area control block with bus tasks, shadow model and watchdog
`timescale 1ns/1ps

module tb_mprj_ctrl;

    localparam int CLK_PERIOD   = 8;
    localparam int XFER_CYCLES  =
        mprj_ctrl_pkg::NUM_PADS * (2 * mprj_ctrl_pkg::IO_CTRL_BITS + 1) + 4;
    localparam int BUS_ACCESSES = 64;
    localparam int BUS_CYCLES   = 4;
    localparam int WATCHDOG_CYCLES = 2 * (3 * XFER_CYCLES + BUS_ACCESSES * BUS_CYCLES);
    localparam int ACK_LIMIT    = 16;
    localparam logic [31:0] OFF_PAGE_ADR = 32'h2400_0008;

    typedef logic [mprj_ctrl_pkg::IO_CTRL_BITS-1:0] word_t;

    logic                                clk;
    logic                                resetn;
    mprj_ctrl_pkg::wb_req_t              wb_req;
    mprj_ctrl_pkg::wb_rsp_t              wb_rsp;
    logic [mprj_ctrl_pkg::NUM_PADS-1:0]  gpio_in;
    logic [mprj_ctrl_pkg::NUM_PADS-1:0]  gpio_out;
    logic [mprj_ctrl_pkg::NUM_PADS-1:0]  gpio_oe;
    logic [mprj_ctrl_pkg::PWR_PADS-1:0]  pwr_ctrl;
    logic                                jtag_oenb;
    logic                                sdo_oenb;
    logic                                busy;
    mprj_ctrl_pkg::serial_cfg_t          serial;
    mprj_ctrl_pkg::pad_cfg_arr_t         pad_cfg;

    // Shadow model of the register file and of what the pads see
    logic [31:0] lcg_state = 32'd29;
    word_t       shadow_cfg   [mprj_ctrl_pkg::NUM_PADS];
    word_t       shadow_chain [mprj_ctrl_pkg::NUM_PADS];
    logic [mprj_ctrl_pkg::PWR_PADS-1:0] shadow_pwr;
    int test_fails   = 0;
    int check_fails  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    mprj_ctrl_top dut (
        .clk             (clk),
        .resetn          (resetn),
        .wb_req_i        (wb_req),
        .wb_rsp_o        (wb_rsp),
        .mgmt_gpio_in_i  (gpio_in),
        .mgmt_gpio_out_o (gpio_out),
        .mgmt_gpio_oe_o  (gpio_oe),
        .pwr_ctrl_o      (pwr_ctrl),
        .jtag_oenb_o     (jtag_oenb),
        .sdo_oenb_o      (sdo_oenb),
        .busy_o          (busy),
        .serial_o        (serial),
        .pad_cfg_o       (pad_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Pad n's word sits 4n bytes above the first pad offset
    function automatic logic [7:0] pad_ofs(input int n);
        return mprj_ctrl_pkg::IOCFG_OFS + 8'(4 * n);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            test_fails++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        test_fails++;
    endtask

    task automatic bus_access(input logic [31:0] adr, input logic we, input logic [31:0] wdat,
                              input logic [3:0] sel, output logic [31:0] rdat);
        int waited;
        @(posedge clk);
        wb_req.adr <= adr;
        wb_req.dat <= wdat;
        wb_req.sel <= sel;
        wb_req.we  <= we;
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < ACK_LIMIT);
        if (!wb_rsp.ack) begin
            report_error($sformatf("no ack for bus access to 0x%08h", adr));
        end
        rdat = wb_rsp.dat;
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] ofs, input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] rdat_ignored;
        bus_access(mprj_ctrl_pkg::BASE_ADR | 32'(ofs), 1'b1, dat, sel, rdat_ignored);
    endtask

    task automatic bus_read(input logic [7:0] ofs, output logic [31:0] dat);
        bus_access(mprj_ctrl_pkg::BASE_ADR | 32'(ofs), 1'b0, 32'd0, 4'hF, dat);
    endtask

    // Hold a request outside the page for a few cycles without an ack
    task automatic probe_off_page();
        @(posedge clk);
        wb_req <= '{adr: OFF_PAGE_ADR, dat: 32'd0, sel: 4'hF, we: 1'b0, cyc: 1'b1, stb: 1'b1};
        repeat (4) begin
            @(posedge clk);
            if (wb_rsp.ack) begin
                report_error("ack seen for an off-page address");
            end
        end
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
    endtask

    task automatic run_transfer(input string name);
        logic [31:0] rdat;
        int polls;
        bus_write(mprj_ctrl_pkg::XFER_OFS, 32'd1, 4'hF);
        bus_read(mprj_ctrl_pkg::XFER_OFS, rdat);
        check_value({name, " busy after start"}, 32'd1, rdat);
        polls = 0;
        while (rdat[0] && polls < XFER_CYCLES) begin
            bus_read(mprj_ctrl_pkg::XFER_OFS, rdat);
            polls++;
        end
        if (rdat[0]) begin
            report_error("loader busy never cleared after the transfer");
        end
        // Pad NUM_PADS-1 goes out first and shifts through to the far cell
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            shadow_chain[i] = shadow_cfg[i];
        end
    endtask

    task automatic finish_test(input string name);
        if (test_fails == 0) begin
            $display("test %-18s ok", name);
            tests_passed++;
        end else begin
            $display("test %-18s %0d failing checks", name, test_fails);
            tests_failed++;
            check_fails += test_fails;
        end
        test_fails = 0;
    endtask

    initial begin
        logic [31:0] rdat;
        logic [31:0] w;
        logic [mprj_ctrl_pkg::NUM_PADS-1:0] mask;
        word_t exp_word;
        resetn  <= 1'b0;
        wb_req  <= '0;
        gpio_in <= '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        // Pads 0 and 1 come up bidirectional and the rest as inputs
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            exp_word = (i < 2) ? 13'h1803 : 13'h0403;
            bus_read(pad_ofs(i), rdat);
            check_value($sformatf("reset_defaults pad %0d", i), 32'(exp_word), rdat);
            check_value($sformatf("reset_defaults pad_cfg_o %0d", i), 32'(exp_word),
                        32'(pad_cfg[i].raw));
            shadow_cfg[i]   = exp_word;
            shadow_chain[i] = exp_word;
        end
        check_value("reset_defaults jtag_oenb", 32'd1, 32'(jtag_oenb));
        check_value("reset_defaults sdo_oenb", 32'd1, 32'(sdo_oenb));
        bus_read(mprj_ctrl_pkg::XFER_OFS, rdat);
        check_value("reset_defaults busy", 32'd0, rdat);
        check_value("reset_defaults pwr_ctrl", 32'd0, 32'(pwr_ctrl));
        finish_test("reset_defaults");

        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            w = next_rand();
            bus_write(pad_ofs(i), w, 4'hF);
            shadow_cfg[i] = w[mprj_ctrl_pkg::IO_CTRL_BITS-1:0];
        end
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            bus_read(pad_ofs(i), rdat);
            check_value($sformatf("register_readback pad %0d", i), 32'(shadow_cfg[i]), rdat);
        end
        w = next_rand();
        bus_write(mprj_ctrl_pkg::PWR_OFS, w, 4'hF);
        shadow_pwr = w[mprj_ctrl_pkg::PWR_PADS-1:0];
        bus_read(mprj_ctrl_pkg::PWR_OFS, rdat);
        check_value("register_readback pwr", 32'(shadow_pwr), rdat);
        check_value("register_readback pwr_ctrl", 32'(shadow_pwr), 32'(pwr_ctrl));
        // Upper byte lanes alone write nothing
        bus_write(mprj_ctrl_pkg::PWR_OFS, ~w, 4'hE);
        bus_write(pad_ofs(3), 32'(~shadow_cfg[3]), 4'b0010);
        bus_read(mprj_ctrl_pkg::PWR_OFS, rdat);
        check_value("register_readback pwr no sel0", 32'(shadow_pwr), rdat);
        bus_read(pad_ofs(3), rdat);
        check_value("register_readback pad 3 no sel0", 32'(shadow_cfg[3]), rdat);
        probe_off_page();
        finish_test("register_readback");

        w = next_rand();
        bus_write(mprj_ctrl_pkg::IODATA_OFS, w, 4'hF);
        check_value("gpio out", 32'(w[mprj_ctrl_pkg::NUM_PADS-1:0]), 32'(gpio_out));
        w = next_rand();
        @(posedge clk);
        gpio_in <= w[mprj_ctrl_pkg::NUM_PADS-1:0];
        bus_read(mprj_ctrl_pkg::IODATA_OFS, rdat);
        check_value("gpio in", 32'(w[mprj_ctrl_pkg::NUM_PADS-1:0]), rdat);
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            check_value($sformatf("gpio oe pad %0d", i), 32'(shadow_cfg[i][3]),
                        32'(gpio_oe[i]));
        end
        // Flip oeb on pads 0 and 1 so the overrides must follow before any transfer
        for (int i = 0; i < 2; i++) begin
            shadow_cfg[i][1] = ~shadow_cfg[i][1];
            bus_write(pad_ofs(i), 32'(shadow_cfg[i]), 4'hF);
        end
        check_value("gpio jtag_oenb", 32'(shadow_cfg[0][1]), 32'(jtag_oenb));
        check_value("gpio sdo_oenb", 32'(shadow_cfg[1][1]), 32'(sdo_oenb));
        finish_test("gpio");

        run_transfer("serial_transfer");
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            check_value($sformatf("serial_transfer pad %0d", i), 32'(shadow_chain[i]),
                        32'(pad_cfg[i].raw));
        end
        finish_test("serial_transfer");

        w = next_rand();
        mask = w[15:8];
        if (mask == '0 || mask == '1) begin
            mask = 8'h24;
        end
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            if (mask[i]) begin
                w = next_rand();
                exp_word = w[mprj_ctrl_pkg::IO_CTRL_BITS-1:0];
                if (exp_word == shadow_cfg[i]) begin
                    exp_word[0] = ~exp_word[0];
                end
                shadow_cfg[i] = exp_word;
                bus_write(pad_ofs(i), 32'(exp_word), 4'hF);
            end
        end
        run_transfer("partial_update");
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            check_value($sformatf("partial_update pad %0d", i), 32'(shadow_chain[i]),
                        32'(pad_cfg[i].raw));
        end
        finish_test("partial_update");

        $display("tests passed %0d, tests failed %0d, failing checks %0d, assertion failures %0d",
                 tests_passed, tests_failed, check_fails, dut.u_asserts.fail_total);
        if (check_fails == 0 && dut.u_asserts.fail_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* testbench/mprj_ctrl_asserts.sv */
// Concurrent checks on the control block's bus ack, serial loader timing and chain strobes
`timescale 1ns/1ps

module mprj_ctrl_asserts (
    input  logic                        clk,
    input  logic                        resetn,
    input  mprj_ctrl_pkg::wb_req_t      wb_req_i,
    input  mprj_ctrl_pkg::wb_rsp_t      wb_rsp_i,
    input  logic                        busy_i,
    input  mprj_ctrl_pkg::serial_cfg_t  serial_i
);

    // START plus 26 XBYTE cycles per pad, then the 4 LOAD cycles
    localparam int XFER_CYCLES = mprj_ctrl_pkg::NUM_PADS * (2 * mprj_ctrl_pkg::IO_CTRL_BITS + 1) + 4;

    logic        off_page;
    logic [15:0] busy_len;
    int unsigned ack_fails  = 0;
    int unsigned page_fails = 0;
    int unsigned rstn_fails = 0;
    int unsigned sclk_fails = 0;
    int unsigned busy_fails = 0;
    int unsigned fail_total;

    assign off_page = wb_req_i.cyc & wb_req_i.stb &
                      (wb_req_i.adr[31:8] != mprj_ctrl_pkg::BASE_ADR[31:8]);
    assign fail_total = ack_fails + page_fails + rstn_fails + sclk_fails + busy_fails;

    // Consecutive cycles with busy high
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_len <= '0;
        end else if (busy_i) begin
            busy_len <= busy_len + 16'd1;
        end else begin
            busy_len <= '0;
        end
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            $error("bus ack stayed high for more than one cycle");
            ack_fails++;
        end

    no_off_page_ack: assert property (@(posedge clk) disable iff (!resetn)
        off_page |=> !wb_rsp_i.ack)
        else begin
            $error("bus ack returned for an address outside the register page");
            page_fails++;
        end

    load_strobe_in_load: assert property (@(posedge clk) disable iff (!resetn)
        $fell(serial_i.resetn) |-> (serial_i.clock && busy_i))
        else begin
            $error("serial resetn fell outside the load sequence");
            rstn_fails++;
        end

    sclk_idle_low: assert property (@(posedge clk) disable iff (!resetn)
        !busy_i |-> !serial_i.clock)
        else begin
            $error("serial clock high while the loader is idle");
            sclk_fails++;
        end

    busy_not_too_long: assert property (@(posedge clk) disable iff (!resetn)
        busy_i |-> (busy_len < XFER_CYCLES))
        else begin
            $error("loader busy longer than one full transfer");
            busy_fails++;
        end

    busy_exact_length: assert property (@(posedge clk) disable iff (!resetn)
        $fell(busy_i) |-> (busy_len == XFER_CYCLES))
        else begin
            $error("loader busy period differs from one full transfer");
            busy_fails++;
        end

endmodule

bind mprj_ctrl_top mprj_ctrl_asserts u_asserts (
    .clk      (clk),
    .resetn   (resetn),
    .wb_req_i (wb_req_i),
    .wb_rsp_i (wb_rsp_o),
    .busy_i   (busy_o),
    .serial_i (serial_o)
);

/* verilog/mprj_ctrl_top.sv */
// User-area control top: register file, serial loader and pad config chain
`timescale 1ns/1ps

module mprj_ctrl_top (
    input  logic                                clk,
    input  logic                                resetn,
    input  mprj_ctrl_pkg::wb_req_t              wb_req_i,
    output mprj_ctrl_pkg::wb_rsp_t              wb_rsp_o,
    input  logic [mprj_ctrl_pkg::NUM_PADS-1:0]  mgmt_gpio_in_i,
    output logic [mprj_ctrl_pkg::NUM_PADS-1:0]  mgmt_gpio_out_o,
    output logic [mprj_ctrl_pkg::NUM_PADS-1:0]  mgmt_gpio_oe_o,
    output logic [mprj_ctrl_pkg::PWR_PADS-1:0]  pwr_ctrl_o,
    output logic                                jtag_oenb_o,
    output logic                                sdo_oenb_o,
    output logic                                busy_o,
    output mprj_ctrl_pkg::serial_cfg_t          serial_o,
    output mprj_ctrl_pkg::pad_cfg_arr_t         pad_cfg_o
);

    // Register image handed to the loader
    mprj_ctrl_pkg::pad_cfg_arr_t reg_pad_cfg;
    logic                        xfer_start;

    mprj_ctrl_regs u_regs (
        .clk             (clk),
        .resetn          (resetn),
        .wb_req_i        (wb_req_i),
        .wb_rsp_o        (wb_rsp_o),
        .mgmt_gpio_in_i  (mgmt_gpio_in_i),
        .mgmt_gpio_out_o (mgmt_gpio_out_o),
        .mgmt_gpio_oe_o  (mgmt_gpio_oe_o),
        .pwr_ctrl_o      (pwr_ctrl_o),
        .pad_cfg_o       (reg_pad_cfg),
        .xfer_start_o    (xfer_start),
        .busy_i          (busy_o),
        .jtag_oenb_o     (jtag_oenb_o),
        .sdo_oenb_o      (sdo_oenb_o)
    );

    serial_cfg_loader u_loader (
        .clk          (clk),
        .resetn       (resetn),
        .xfer_start_i (xfer_start),
        .pad_cfg_i    (reg_pad_cfg),
        .busy_o       (busy_o),
        .serial_o     (serial_o)
    );

    pad_cfg_chain u_chain (
        .clk       (clk),
        .resetn    (resetn),
        .serial_i  (serial_o),
        .pad_cfg_o (pad_cfg_o)
    );

endmodule

/* verilog/pad_cfg_chain.sv */
// Pad config chain: per-pad shift and config cells fed by the serial loader
`timescale 1ns/1ps

module pad_cfg_chain (
    input  logic                         clk,
    input  logic                         resetn,
    input  mprj_ctrl_pkg::serial_cfg_t   serial_i,
    output mprj_ctrl_pkg::pad_cfg_arr_t  pad_cfg_o
);

    logic                                    clk_q;
    logic                                    rstn_q;
    logic                                    shift_en;
    logic                                    load_en;
    logic [mprj_ctrl_pkg::NUM_PADS-1:0]      cell_in;
    logic [mprj_ctrl_pkg::IO_CTRL_BITS-1:0]  shift_q [mprj_ctrl_pkg::NUM_PADS];
    logic [mprj_ctrl_pkg::IO_CTRL_BITS-1:0]  cfg_q   [mprj_ctrl_pkg::NUM_PADS];

    // Previous samples of the serial strobes
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            clk_q  <= 1'b0;
            rstn_q <= 1'b0;
        end else begin
            clk_q  <= serial_i.clock;
            rstn_q <= serial_i.resetn;
        end
    end

    assign shift_en = serial_i.clock & ~clk_q;
    assign load_en  = serial_i.resetn & ~rstn_q;

    for (genvar i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin : g_cell
        // Cell 0 takes the serial data, later cells take the MSB of the one before
        if (i == 0) begin : g_head
            assign cell_in[i] = serial_i.data;
        end else begin : g_link
            assign cell_in[i] = shift_q[i-1][mprj_ctrl_pkg::SER_CLK_PAD];
        end

        always_ff @(posedge clk or negedge resetn) begin
            if (!resetn) begin
                shift_q[i] <= mprj_ctrl_pkg::PAD_CFG_RESET[i].raw;
                cfg_q[i]   <= mprj_ctrl_pkg::PAD_CFG_RESET[i].raw;
            end else begin
                if (shift_en) begin
                    shift_q[i] <= {shift_q[i][mprj_ctrl_pkg::SER_CLK_PAD-1:0], cell_in[i]};
                end
                // Latch the shifted word on the load strobe
                if (load_en) begin
                    cfg_q[i] <= shift_q[i];
                end
            end
        end

        assign pad_cfg_o[i].raw = cfg_q[i];
    end

endmodule

/* verilog/serial_cfg_loader.sv */
// Serial config loader that shifts every pad word out MSB first and then pulses the load strobe
`timescale 1ns/1ps

module serial_cfg_loader (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         xfer_start_i,
    input  mprj_ctrl_pkg::pad_cfg_arr_t  pad_cfg_i,
    output logic                         busy_o,
    output mprj_ctrl_pkg::serial_cfg_t   serial_o
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        XBYTE = 2'd2,
        LOAD  = 2'd3
    } state_e;

    state_e                                  state_q;
    logic [mprj_ctrl_pkg::BIT_CNT_W-1:0]     bit_cnt_q;
    logic [mprj_ctrl_pkg::PAD_IDX_W-1:0]     pad_cnt_q;
    logic [mprj_ctrl_pkg::IO_CTRL_BITS-1:0]  staging_q;
    logic                                    ser_clk_q;
    logic                                    ser_rstn_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q    <= IDLE;
            bit_cnt_q  <= '0;
            pad_cnt_q  <= mprj_ctrl_pkg::PAD_IDX_W'(mprj_ctrl_pkg::NUM_PADS - 1);
            staging_q  <= '0;
            ser_clk_q  <= 1'b0;
            ser_rstn_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    ser_rstn_q <= 1'b1;
                    ser_clk_q  <= 1'b0;
                    pad_cnt_q  <= mprj_ctrl_pkg::PAD_IDX_W'(mprj_ctrl_pkg::NUM_PADS - 1);
                    if (xfer_start_i) begin
                        state_q <= START;
                    end
                end
                START: begin
                    // Highest pad goes first so it ends in the far cell
                    staging_q <= pad_cfg_i[pad_cnt_q].raw;
                    bit_cnt_q <= '0;
                    ser_clk_q <= 1'b0;
                    state_q   <= XBYTE;
                end
                XBYTE: begin
                    ser_clk_q <= ~ser_clk_q;
                    // Advance data as the clock falls
                    if (ser_clk_q) begin
                        staging_q <= {staging_q[mprj_ctrl_pkg::SER_CLK_PAD-1:0], 1'b0};
                        if (bit_cnt_q == mprj_ctrl_pkg::BIT_CNT_W'(mprj_ctrl_pkg::SER_CLK_PAD)) begin
                            bit_cnt_q <= '0;
                            if (pad_cnt_q == '0) begin
                                // Clock stays high into the load sequence
                                ser_clk_q <= 1'b1;
                                state_q   <= LOAD;
                            end else begin
                                pad_cnt_q <= pad_cnt_q - 1'b1;
                                state_q   <= START;
                            end
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                LOAD: begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    case (bit_cnt_q)
                        mprj_ctrl_pkg::BIT_CNT_W'(0): ser_rstn_q <= 1'b0;
                        mprj_ctrl_pkg::BIT_CNT_W'(1): ser_rstn_q <= 1'b1;
                        mprj_ctrl_pkg::BIT_CNT_W'(2): ser_clk_q  <= 1'b0;
                        default: state_q <= IDLE;
                    endcase
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign busy_o          = (state_q != IDLE);
    assign serial_o.clock  = ser_clk_q;
    assign serial_o.resetn = ser_rstn_q;
    assign serial_o.data   = staging_q[mprj_ctrl_pkg::SER_CLK_PAD];

endmodule

/* verilog/mprj_ctrl_regs.sv */
// User-area control registers: Wishbone slave for pad config, GPIO, power and transfer start
`timescale 1ns/1ps

module mprj_ctrl_regs (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  mprj_ctrl_pkg::wb_req_t                 wb_req_i,
    output mprj_ctrl_pkg::wb_rsp_t                 wb_rsp_o,
    input  logic [mprj_ctrl_pkg::NUM_PADS-1:0]     mgmt_gpio_in_i,
    output logic [mprj_ctrl_pkg::NUM_PADS-1:0]     mgmt_gpio_out_o,
    output logic [mprj_ctrl_pkg::NUM_PADS-1:0]     mgmt_gpio_oe_o,
    output logic [mprj_ctrl_pkg::PWR_PADS-1:0]     pwr_ctrl_o,
    output mprj_ctrl_pkg::pad_cfg_arr_t            pad_cfg_o,
    output logic                                   xfer_start_o,
    input  logic                                   busy_i,
    output logic                                   jtag_oenb_o,
    output logic                                   sdo_oenb_o
);

    logic                                   valid;
    logic                                   page_hit;
    logic                                   acc;
    logic                                   wr_en;
    logic [7:0]                             ofs;
    logic                                   xfer_sel;
    logic                                   pwr_sel;
    logic                                   iodata_sel;
    logic [mprj_ctrl_pkg::NUM_PADS-1:0]     pad_sel;
    logic                                   rd_hit;
    logic [31:0]                            rd_data;

    logic                                   ack_q;
    logic [31:0]                            rd_dat_q;
    logic                                   xfer_start_q;
    logic [mprj_ctrl_pkg::PWR_PADS-1:0]     pwr_q;
    logic [mprj_ctrl_pkg::NUM_PADS-1:0]     gpio_out_q;
    mprj_ctrl_pkg::pad_cfg_arr_t            pad_cfg_q;

    // Page decode, one access per request until ack has been seen
    assign valid    = wb_req_i.cyc & wb_req_i.stb;
    assign page_hit = (wb_req_i.adr[31:8] == mprj_ctrl_pkg::BASE_ADR[31:8]);
    assign acc      = valid & page_hit & ~ack_q;
    // Only the lowest byte lane enables a write
    assign wr_en    = acc & wb_req_i.we & wb_req_i.sel[0];

    assign ofs        = wb_req_i.adr[7:0];
    assign xfer_sel   = (ofs == mprj_ctrl_pkg::XFER_OFS);
    assign pwr_sel    = (ofs == mprj_ctrl_pkg::PWR_OFS);
    assign iodata_sel = (ofs == mprj_ctrl_pkg::IODATA_OFS);

    // Pad n sits at IOCFG_OFS + 4n
    for (genvar i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin : g_pad_sel
        assign pad_sel[i] = (ofs == mprj_ctrl_pkg::IOCFG_OFS + 8'(4 * i));
    end

    // Read mux
    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        if (xfer_sel) begin
            rd_data = {31'b0, busy_i};
        end else if (pwr_sel) begin
            rd_data = {{(32-mprj_ctrl_pkg::PWR_PADS){1'b0}}, pwr_q};
        end else if (iodata_sel) begin
            rd_data = {{(32-mprj_ctrl_pkg::NUM_PADS){1'b0}}, mgmt_gpio_in_i};
        end else if (|pad_sel) begin
            for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
                if (pad_sel[i]) begin
                    rd_data = {{(32-mprj_ctrl_pkg::IO_CTRL_BITS){1'b0}}, pad_cfg_q[i].raw};
                end
            end
        end else begin
            rd_hit = 1'b0;
        end
    end

    // Control registers and the one-cycle ack
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_q        <= 1'b0;
            xfer_start_q <= 1'b0;
            pwr_q        <= '0;
            gpio_out_q   <= '0;
            pad_cfg_q    <= mprj_ctrl_pkg::PAD_CFG_RESET;
        end else begin
            ack_q        <= acc;
            xfer_start_q <= 1'b0;
            if (wr_en) begin
                if (xfer_sel) begin
                    xfer_start_q <= wb_req_i.dat[0];
                end
                if (pwr_sel) begin
                    pwr_q <= wb_req_i.dat[mprj_ctrl_pkg::PWR_PADS-1:0];
                end
                if (iodata_sel) begin
                    gpio_out_q <= wb_req_i.dat[mprj_ctrl_pkg::NUM_PADS-1:0];
                end
                for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
                    if (pad_sel[i]) begin
                        pad_cfg_q[i].raw <= wb_req_i.dat[mprj_ctrl_pkg::IO_CTRL_BITS-1:0];
                    end
                end
            end
        end
    end

    // Read data holds when the offset decodes to nothing
    always_ff @(posedge clk) begin
        if (acc && !wb_req_i.we && rd_hit) begin
            rd_dat_q <= rd_data;
        end
    end

    // Output enable per pad comes from its input-disable bit
    always_comb begin
        for (int i = 0; i < mprj_ctrl_pkg::NUM_PADS; i++) begin
            mgmt_gpio_oe_o[i] = pad_cfg_q[i].fields.inp_dis;
        end
    end

    assign wb_rsp_o.dat     = rd_dat_q;
    assign wb_rsp_o.ack     = ack_q;
    assign mgmt_gpio_out_o  = gpio_out_q;
    assign pwr_ctrl_o       = pwr_q;
    assign pad_cfg_o        = pad_cfg_q;
    assign xfer_start_o     = xfer_start_q;

    // JTAG and SDO override state straight from the register copy
    assign jtag_oenb_o = pad_cfg_q[0].fields.oeb;
    assign sdo_oenb_o  = pad_cfg_q[1].fields.oeb;

endmodule

/* verilog/mprj_ctrl_pkg.sv */
// User-area control package: sizes, register map, pad reset values and bus types
package mprj_ctrl_pkg;

    // Sizes
    localparam int NUM_PADS     = 8;
    localparam int PWR_PADS     = 4;
    localparam int IO_CTRL_BITS = 13;

    // Counter widths for the serial loader
    localparam int PAD_IDX_W = $clog2(NUM_PADS);
    localparam int BIT_CNT_W = $clog2(IO_CTRL_BITS);

    // Bit 12 of each word leads on the serial line and links one chain cell to the next
    localparam int SER_CLK_PAD = IO_CTRL_BITS - 1;

    // Register page, only bits 31:8 of the address are compared
    localparam logic [31:0] BASE_ADR = 32'h2300_0000;

    // Register offsets within the page
    localparam logic [7:0] XFER_OFS   = 8'h00;
    localparam logic [7:0] PWR_OFS    = 8'h04;
    localparam logic [7:0] IODATA_OFS = 8'h08;
    localparam logic [7:0] IOCFG_OFS  = 8'h20;

    // Pad configuration reset values
    localparam logic [IO_CTRL_BITS-1:0] CFG_BIDIR_DEFAULT = 13'h1803;
    localparam logic [IO_CTRL_BITS-1:0] CFG_INPUT_DEFAULT = 13'h0403;

    // One pad word, seen as a raw word or by field
    typedef union packed {
        logic [IO_CTRL_BITS-1:0] raw;
        struct packed {
            logic [2:0] dm;
            logic       ana_pol;
            logic       ana_sel;
            logic       ana_en;
            logic       slow;
            logic       vtrip;
            logic       ib_mode;
            logic       inp_dis;
            logic       hold_ovr;
            logic       oeb;
            logic       mgmt_ena;
        } fields;
    } pad_cfg_u;

    typedef pad_cfg_u [NUM_PADS-1:0] pad_cfg_arr_t;

    // Pads 0 and 1 start bidirectional, all others as plain inputs
    localparam pad_cfg_arr_t PAD_CFG_RESET = {
        {(NUM_PADS-2){CFG_INPUT_DEFAULT}},
        CFG_BIDIR_DEFAULT,
        CFG_BIDIR_DEFAULT
    };

    // Wishbone request and response
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // Serial lines from the loader to the pad chain
    typedef struct packed {
        logic clock;
        logic resetn;
        logic data;
    } serial_cfg_t;

endpackage
